// File: mips_pkg.sv
package mips_pkg;

	// Basic widths
	typedef logic [31:0] word_t;	// Data, addresses, registers
	typedef logic [4:0]  reg_addr_t;	// Register index

	localparam reg_addr_t v0_index = 5'd2;	// $v0, return value register

	// Primary opcodes, instr[31:26]
	typedef enum logic [5:0] {
		op_rtype = 6'b000000,	// Decode continues in funct
		op_j     = 6'b000010,
		op_beq   = 6'b000100,
		op_addi  = 6'b001000,
		op_lw    = 6'b100011,
		op_sw    = 6'b101011
	} opcode_t;

	// R-type function field, instr[5:0]
	typedef enum logic [5:0] {
		fn_jr  = 6'b001000,	// Jump to rs, halts on zero
		fn_add = 6'b100000,
		fn_sub = 6'b100010,
		fn_and = 6'b100100,
		fn_or  = 6'b100101,
		fn_slt = 6'b101010	// Signed compare
	} funct_t;

	// ALU operation select
	typedef enum logic [2:0] {
		alu_and = 3'b000,
		alu_or  = 3'b001,
		alu_add = 3'b010,
		alu_sub = 3'b110,	// Also drives BEQ compare
		alu_slt = 3'b111
	} alu_op_t;

	// Instruction word in R-type layout
	// I-type immediate is {rd, shamt, funct}, J index is {rs, rt, rd, shamt, funct}
	typedef struct packed {
		opcode_t   op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t rd;
		logic [4:0] shamt;
		funct_t    funct;
	} instr_t;

	// Decoded control word
	typedef struct packed {
		logic    reg_write;	// Write back to register file
		logic    reg_dst;	// Dest is rd, else rt
		logic    alu_src;	// ALU B is immediate
		logic    branch;	// BEQ
		logic    mem_write;	// SW
		logic    mem_read;	// LW
		logic    mem_to_reg;	// Write back load data
		logic    jump;	// J
		logic    jump_reg;	// JR
		alu_op_t alu_op;
	} ctrl_t;

endpackage

// File: mips_alu.sv
`timescale 1ns/1ns

module mips_alu import mips_pkg::*; (
	input  alu_op_t op,
	input  word_t   a,
	input  word_t   b,
	output word_t   result,
	output logic    zero
);

	logic lt;	// Signed a < b

	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			alu_and: result = a & b;
			alu_or:  result = a | b;
			alu_add: result = a + b;	// Wraps, no overflow trap
			alu_sub: result = a - b;
			alu_slt: result = {31'b0, lt};
			default: result = '0;
		endcase
	end

	// BEQ looks at this after a subtract
	assign zero = (result == '0);

endmodule

// File: mips_regfile.sv
`timescale 1ns/1ns

// 32 x 32 register file, two async reads, one sync write
module mips_regfile import mips_pkg::*; (
	input  logic      clk,
	input  logic      write_en,
	input  reg_addr_t read_addr_a,
	input  reg_addr_t read_addr_b,
	input  reg_addr_t write_addr,
	input  word_t     write_data,
	output word_t     read_data_a,
	output word_t     read_data_b,
	output word_t     v0
);

	word_t regs [32];

	// $zero never stored
	always_ff @(posedge clk) begin
		if (write_en && write_addr != '0)
			regs[write_addr] <= write_data;
	end

	// Entry 0 is forced on read
	assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

	assign v0 = regs[v0_index];	// Observation tap

endmodule

// File: mips_control.sv
`timescale 1ns/1ns

// Main and ALU decode merged into one table
module mips_control import mips_pkg::*; (
	input  instr_t instr,
	output ctrl_t  ctrl
);

	always_comb begin
		// Unlisted opcodes fall through as no-ops
		ctrl = '0;
		ctrl.alu_op = alu_add;

		case (instr.op)
			op_rtype: begin
				ctrl.reg_dst = 1'b1;	// Dest in rd
				case (instr.funct)
					fn_add: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_add;
					end
					fn_sub: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_sub;
					end
					fn_and: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_and;
					end
					fn_or: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_or;
					end
					fn_slt: begin
						ctrl.reg_write = 1'b1;
						ctrl.alu_op = alu_slt;
					end
					fn_jr: ctrl.jump_reg = 1'b1;	// No write back
					default: ctrl.reg_dst = 1'b0;	// Unknown funct, nothing happens
				endcase
			end
			op_lw: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;	// base + offset
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
			end
			op_sw: begin
				ctrl.alu_src = 1'b1;
				ctrl.mem_write = 1'b1;	// Store data from rt
			end
			op_beq: begin
				ctrl.branch = 1'b1;
				ctrl.alu_op = alu_sub;	// Equal when difference is zero
			end
			op_addi: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src = 1'b1;
			end
			op_j: ctrl.jump = 1'b1;
			default: ;	// Keep default word
		endcase
	end

endmodule

// File: mips_datapath.sv
`timescale 1ns/1ns

module mips_datapath import mips_pkg::*; #(
	parameter word_t reset_vector = 32'h0000_1000
) (
	input  logic   clk,
	input  logic   reset,
	input  logic   clk_enable,
	input  ctrl_t  ctrl,
	input  instr_t instr,
	input  word_t  data_readdata,
	output word_t  instr_address,
	output word_t  data_address,
	output word_t  data_writedata,
	output word_t  register_v0,
	output logic   data_write,
	output logic   data_read,
	output logic   active
);

	word_t pc;
	word_t pc_next;
	word_t pc_plus4;
	word_t branch_target;
	word_t jump_target;
	word_t imm_ext;	// Sign-extended immediate
	word_t src_a;
	word_t rt_data;
	word_t src_b;
	word_t alu_result;
	word_t result;	// Write-back value
	reg_addr_t write_reg;
	logic [15:0] imm;
	logic [25:0] index;
	logic zero;
	logic taken;
	logic run;	// Instruction commits this edge
	logic halt_now;	// JR to address zero

	// Immediate and jump index out of the R-type fields
	assign imm = {instr.rd, instr.shamt, instr.funct};
	assign index = {instr.rs, instr.rt, imm};
	assign imm_ext = {{16{imm[15]}}, imm};

	assign run = clk_enable & active;

	// Destination and operand selection
	assign write_reg = ctrl.reg_dst ? instr.rd : instr.rt;
	assign src_b = ctrl.alu_src ? imm_ext : rt_data;
	assign result = ctrl.mem_to_reg ? data_readdata : alu_result;

	mips_regfile rf0 (
		.clk(clk),
		.write_en(ctrl.reg_write & run),	// Frozen or halted, no write
		.read_addr_a(instr.rs),
		.read_addr_b(instr.rt),
		.write_addr(write_reg),
		.write_data(result),
		.read_data_a(src_a),
		.read_data_b(rt_data),
		.v0(register_v0)
	);

	mips_alu alu0 (
		.op(ctrl.alu_op),
		.a(src_a),
		.b(src_b),
		.result(alu_result),
		.zero(zero)
	);

	// Next PC candidates
	assign pc_plus4 = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm_ext[29:0], 2'b00};
	assign jump_target = {pc_plus4[31:28], index, 2'b00};
	assign taken = ctrl.branch & zero;

	// JR wins over J, J over branch
	always_comb begin
		if (ctrl.jump_reg)
			pc_next = src_a;
		else if (ctrl.jump)
			pc_next = jump_target;
		else if (taken)
			pc_next = branch_target;
		else
			pc_next = pc_plus4;
	end

	assign halt_now = ctrl.jump_reg & (src_a == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= reset_vector;
			active <= 1'b1;
		end else if (run) begin
			pc <= pc_next;
			if (halt_now)
				active <= 1'b0;	// Stays low until reset
		end
	end

	assign instr_address = pc;

	// Data bus, strobes only while committing
	assign data_address = alu_result;
	assign data_writedata = rt_data;	// SW stores rt
	assign data_write = ctrl.mem_write & run & ~reset;
	assign data_read = ctrl.mem_read & run & ~reset;

endmodule

// File: mips_cpu_harvard.sv
`timescale 1ns/1ns

// Single-cycle MIPS core, separate instruction and data buses
module mips_cpu_harvard import mips_pkg::*; #(
	parameter word_t reset_vector = 32'h0000_1000	// First fetch address
) (
	input  logic  clk,
	input  logic  reset,
	input  logic  clk_enable,	// Low freezes all state
	output logic  active,	// Drops after JR to zero
	output word_t register_v0,

	// Instruction bus, async read
	output word_t instr_address,
	input  word_t instr_readdata,

	// Data bus, async read, write at edge
	output word_t data_address,
	output logic  data_write,
	output logic  data_read,
	output word_t data_writedata,
	input  word_t data_readdata
);

	ctrl_t ctrl;	// Decoded control word

	mips_control ctrl0 (
		.instr(instr_t'(instr_readdata)),
		.ctrl(ctrl)
	);

	mips_datapath #(
		.reset_vector(reset_vector)
	) dp0 (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.ctrl(ctrl),
		.instr(instr_t'(instr_readdata)),
		.data_readdata(data_readdata),
		.instr_address(instr_address),
		.data_address(data_address),
		.data_writedata(data_writedata),
		.register_v0(register_v0),
		.data_write(data_write),
		.data_read(data_read),
		.active(active)
	);

endmodule

// File: mips_cpu_props.sv
`timescale 1ns/1ns

// Bus and freeze rules checked on the core boundary
module mips_cpu_props import mips_pkg::*; (
	input logic  clk,
	input logic  reset,
	input logic  clk_enable,
	input logic  active,
	input logic  data_write,
	input logic  data_read,
	input word_t instr_address
);

	// One data access per cycle
	no_dual_access: assert property (@(posedge clk) !(data_write && data_read))
		else $error("data_write and data_read high together");

	no_idle_access: assert property (@(posedge clk)
		(reset || !active) |-> (!data_write && !data_read))
		else $error("data access during reset or after halt");

	pc_aligned: assert property (@(posedge clk) disable iff (reset)
		instr_address[1:0] == 2'b00)
		else $error("instr_address not word aligned");

	// Frozen or halted core keeps its PC
	pc_frozen: assert property (@(posedge clk) disable iff (reset)
		(!clk_enable || !active) |=> $stable(instr_address))
		else $error("instr_address moved while frozen or halted");

endmodule

bind mips_cpu_harvard mips_cpu_props props0 (
	.clk(clk),
	.reset(reset),
	.clk_enable(clk_enable),
	.active(active),
	.data_write(data_write),
	.data_read(data_read),
	.instr_address(instr_address)
);

// File: mips_cpu_tb.sv
`timescale 1ns/1ns

module mips_cpu_tb import mips_pkg::*; ();

	localparam word_t rv = 32'h0000_1000;	// DUT reset vector
	localparam int max_enabled = 64;	// Halt must come within this many enabled cycles
	localparam int fixed_index = 64;	// Data word at byte 0x100
	localparam reg_addr_t r0 = 5'd0;
	localparam reg_addr_t t0 = 5'd8;
	localparam reg_addr_t t1 = 5'd9;
	localparam reg_addr_t t2 = 5'd10;
	localparam reg_addr_t t3 = 5'd11;
	localparam reg_addr_t t4 = 5'd12;
	localparam reg_addr_t t5 = 5'd13;
	localparam reg_addr_t t6 = 5'd14;
	localparam word_t halt_word = {op_rtype, r0, r0, r0, 5'd0, fn_jr};	// jr $zero
	// Fetch outside the program, a halted core must never issue this
	localparam word_t stray_word = {op_sw, r0, r0, 16'h0100};

	// One table row
	typedef struct packed {
		logic [11:0][31:0] prog;
		word_t init_word;	// Preload at byte 0x104
		word_t exp_v0;
		word_t exp_mem;	// Word at byte 0x100 after halt
		word_t exp_reads;	// Committed loads
		logic  toggle_en;	// Random clk_enable
	} test_t;

	logic clk;
	logic reset;
	logic clk_enable;
	logic active;
	logic data_write;
	logic data_read;
	word_t register_v0;
	word_t instr_address;
	word_t instr_readdata;
	word_t data_address;
	word_t data_writedata;
	word_t data_readdata;
	word_t rel_addr;
	word_t init_word;
	word_t imem [16];
	word_t dmem [256];
	test_t tests [$];
	string names [$];
	logic table_ready;
	int test_errors;
	int passed;
	int failed;

	mips_cpu_harvard #(.reset_vector(rv)) dut0 (
		.clk(clk),
		.reset(reset),
		.clk_enable(clk_enable),
		.active(active),
		.register_v0(register_v0),
		.instr_address(instr_address),
		.instr_readdata(instr_readdata),
		.data_address(data_address),
		.data_write(data_write),
		.data_read(data_read),
		.data_writedata(data_writedata),
		.data_readdata(data_readdata)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;	// 8 ns period

	// Async read memories
	assign rel_addr = instr_address - rv;
	assign instr_readdata = (rel_addr < 32'd64) ? imem[rel_addr[5:2]] : stray_word;
	assign data_readdata = dmem[data_address[9:2]];

	function automatic word_t fill_word(input int idx);
		return {16'hd0a0, ~idx[7:0], idx[7:0]};
	endfunction

	// Data memory reloads itself during reset
	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 256; i++)
				dmem[i] <= fill_word(i);
			dmem[fixed_index + 1] <= init_word;
		end else if (data_write) begin
			dmem[data_address[9:2]] <= data_writedata;
		end
	end

	function automatic word_t r_word(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd);
		return {op_rtype, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic word_t i_word(opcode_t op, reg_addr_t rs, reg_addr_t rt,
			logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic word_t j_word(input int slot);
		word_t target;
		target = rv + 32'(slot * 4);
		return {op_j, target[27:2]};	// Upper bits come from PC+4
	endfunction

	function automatic word_t sext(logic [15:0] imm);
		return {{16{imm[15]}}, imm};
	endfunction

	// ISA result of one R-type op, 32-bit wrap, signed SLT
	function automatic word_t expected_result(funct_t fn, word_t x, word_t y);
		case (fn)
			fn_add: return x + y;
			fn_sub: return x - y;
			fn_and: return x & y;
			fn_or:  return x | y;
			fn_slt: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
			default: return '0;
		endcase
	endfunction

	function automatic test_t blank_entry();
		test_t e;
		e = '0;
		for (int i = 0; i < 12; i++)
			e.prog[i] = halt_word;	// Unused slots halt
		e.exp_mem = fill_word(fixed_index);
		return e;
	endfunction

	task automatic add_entry(input string nm, input test_t e);
		tests.push_back(e);
		names.push_back(nm);
	endtask

	task automatic report_mismatch(input string sig, input word_t expv, input word_t got);
		$display("ERR %0t %s expected %h got %h", $time, sig, expv, got);
		test_errors++;
	endtask

	task automatic run_entry(input test_t t, input string nm);
		int enabled;
		word_t reads;
		word_t held_v0;
		word_t held_addr;
		logic stray;
		logic [31:0] rnd;
		test_errors = 0;
		@(posedge clk);
		#1;
		reset = 1'b1;
		clk_enable = 1'b1;
		init_word = t.init_word;
		for (int i = 0; i < 16; i++)
			imem[i] = (i < 12) ? t.prog[i] : halt_word;
		repeat (5) @(posedge clk);
		#1;
		reset = 1'b0;
		enabled = 0;
		reads = '0;
		while (active && enabled < max_enabled) begin
			rnd = $urandom;
			clk_enable = t.toggle_en ? rnd[0] : 1'b1;
			if (clk_enable)
				enabled++;
			@(negedge clk);
			if (data_read)
				reads++;	// Mid-cycle, one per committed load
			@(posedge clk);
			#1;	// Outputs settled, drive next cycle
		end
		clk_enable = 1'b1;
		assert (!active) else begin
			$display("Test %s: the core did not halt within %0d enabled cycles",
				nm, max_enabled);
			test_errors++;
		end
		assert (reads == t.exp_reads) else report_mismatch("data_read", t.exp_reads, reads);
		if (!active) begin
			held_v0 = register_v0;
			held_addr = instr_address;
			stray = 1'b0;
			repeat (10) begin
				@(posedge clk);
				#1;
				stray |= data_write;
			end
			assert (!stray) else report_mismatch("data_write", 32'd0, 32'd1);
			assert (register_v0 == held_v0) else
				report_mismatch("register_v0", held_v0, register_v0);
			assert (instr_address == held_addr) else
				report_mismatch("instr_address", held_addr, instr_address);
		end
		assert (register_v0 == t.exp_v0) else
			report_mismatch("register_v0", t.exp_v0, register_v0);
		assert (dmem[fixed_index] == t.exp_mem) else
			report_mismatch("dmem[0x100]", t.exp_mem, dmem[fixed_index]);
		if (test_errors == 0) begin
			passed++;
			$display("Test %s: ok", nm);
		end else begin
			failed++;
			$display("Test %s: failed with %0d errors", nm, test_errors);
		end
	endtask

	initial begin
		word_t a, b, x2, x3, x4, x5, x6, jr_target;
		logic [31:0] rnd;
		test_t cur;
		funct_t ops [5];
		reset = 1'b1;
		clk_enable = 1'b0;
		init_word = '0;
		table_ready = 1'b0;
		passed = 0;
		failed = 0;
		for (int i = 0; i < 16; i++)
			imem[i] = halt_word;
		rnd = $urandom(32'haccf_afeb);
		ops = '{fn_add, fn_sub, fn_and, fn_or, fn_slt};
		// One entry per R-type op on random operands
		for (int k = 0; k < 5; k++) begin
			rnd = $urandom;
			cur = blank_entry();
			cur.prog[0] = i_word(op_addi, r0, t0, rnd[15:0]);
			cur.prog[1] = i_word(op_addi, r0, t1, rnd[31:16]);
			cur.prog[2] = r_word(ops[k], t0, t1, v0_index);
			cur.exp_v0 = expected_result(ops[k], sext(rnd[15:0]), sext(rnd[31:16]));
			add_entry(ops[k].name(), cur);
		end
		// All five ops chained into v0
		rnd = $urandom;
		a = sext(rnd[15:0]);
		b = sext(rnd[31:16]);
		cur = blank_entry();
		cur.prog[0] = i_word(op_addi, r0, t0, rnd[15:0]);
		cur.prog[1] = i_word(op_addi, r0, t1, rnd[31:16]);
		cur.prog[2] = r_word(fn_add, t0, t1, t2);
		cur.prog[3] = r_word(fn_sub, t0, t1, t3);
		cur.prog[4] = r_word(fn_and, t2, t3, t4);
		cur.prog[5] = r_word(fn_or, t4, t0, t5);
		cur.prog[6] = r_word(fn_slt, t3, t1, t6);
		cur.prog[7] = r_word(fn_add, t5, t6, v0_index);
		x2 = expected_result(fn_add, a, b);
		x3 = expected_result(fn_sub, a, b);
		x4 = expected_result(fn_and, x2, x3);
		x5 = expected_result(fn_or, x4, a);
		x6 = expected_result(fn_slt, x3, b);
		cur.exp_v0 = expected_result(fn_add, x5, x6);
		add_entry("alu_chain", cur);
		cur.toggle_en = 1'b1;	// Same program, stalled at random
		add_entry("clock_enable", cur);
		// $zero swallows writes
		cur = blank_entry();
		cur.prog[0] = i_word(op_addi, r0, r0, 16'h1234);
		cur.prog[1] = i_word(op_addi, r0, t0, 16'h7abc);
		cur.prog[2] = r_word(fn_add, t0, t0, r0);
		cur.prog[3] = r_word(fn_add, r0, t0, v0_index);
		cur.exp_v0 = 32'h0000_7abc;
		add_entry("reg_zero", cur);
		// Store, load back, add preloaded word
		rnd = $urandom;
		cur = blank_entry();
		cur.init_word = rnd;
		cur.prog[0] = i_word(op_addi, r0, t0, 16'h0123);
		cur.prog[1] = i_word(op_addi, r0, t1, 16'h0100);	// Base of fixed word
		cur.prog[2] = i_word(op_sw, t1, t0, 16'h0000);
		cur.prog[3] = i_word(op_lw, t1, t2, 16'h0000);
		cur.prog[4] = i_word(op_lw, t1, t3, 16'h0004);
		cur.prog[5] = r_word(fn_add, t2, t3, v0_index);
		cur.exp_v0 = 32'h0000_0123 + rnd;
		cur.exp_mem = 32'h0000_0123;
		cur.exp_reads = 32'd2;	// Two LW
		add_entry("load_store", cur);
		// Each v0 bit marks one path
		cur = blank_entry();
		cur.prog[0] = i_word(op_addi, r0, t0, 16'd5);
		cur.prog[1] = i_word(op_addi, r0, t1, 16'd5);
		cur.prog[2] = i_word(op_addi, r0, v0_index, 16'd1);
		cur.prog[3] = i_word(op_beq, t0, t1, 16'd1);	// Taken
		cur.prog[4] = i_word(op_addi, v0_index, v0_index, 16'd16);
		cur.prog[5] = i_word(op_addi, r0, t1, 16'd6);
		cur.prog[6] = i_word(op_beq, t0, t1, 16'd1);	// Falls through
		cur.prog[7] = i_word(op_addi, v0_index, v0_index, 16'd2);
		cur.prog[8] = j_word(10);
		cur.prog[9] = i_word(op_addi, v0_index, v0_index, 16'd64);
		cur.prog[10] = i_word(op_addi, v0_index, v0_index, 16'd4);
		cur.exp_v0 = 32'd7;
		add_entry("branch_jump", cur);
		// JR to nonzero continues, JR to zero halts
		jr_target = rv + 32'd12;
		cur = blank_entry();
		cur.prog[0] = i_word(op_addi, r0, t0, jr_target[15:0]);
		cur.prog[1] = r_word(fn_jr, t0, r0, r0);
		cur.prog[2] = i_word(op_addi, r0, v0_index, 16'h0099);
		cur.prog[3] = i_word(op_addi, r0, v0_index, 16'h0042);
		cur.exp_v0 = 32'h0000_0042;
		add_entry("jr_halt", cur);
		table_ready = 1'b1;
		for (int n = 0; n < tests.size(); n++)
			run_entry(tests[n], names[n]);
		$display("Tests passed %0d failed %0d", passed, failed);
		if (failed == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	// 80 cycles per entry is well above reset, run and hold time
	initial begin
		wait (table_ready);
		#(tests.size() * 80 * 8);
		$display("Watchdog expired before all tests finished");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: src.f
mips_pkg.sv
mips_alu.sv
mips_regfile.sv
mips_control.sv
mips_datapath.sv
mips_cpu_harvard.sv
mips_cpu_props.sv
mips_cpu_tb.sv

// File: Makefile
# Verilator build and run for the single-cycle MIPS core

VERILATOR ?= verilator
TOP       ?= mips_cpu_tb
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
# Extra Verilator options, e.g. VFLAGS=-O3
VFLAGS    ?=

SRCS := $(wildcard *.sv)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) $(VFLAGS) -f src.f

$(BIN): $(SRCS) src.f
	$(VERILATOR) --binary --timing --assert --top-module $(TOP) \
		--Mdir $(OBJ_DIR) $(VFLAGS) -f src.f

# Pass only if the log holds the pass line
sim: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
